//--- verilog.f
+incdir+hw
hw/db_pkg.sv
hw/mem_ram_sdp_sync.sv
hw/db_store_array.sv
hw/db_cmd_ctrl.sv
hw/db_engine.sv
verification/tb_clkgen.sv
verification/tb_db_engine.sv

//--- Makefile
# Any of these can be set on the command line, e.g. make test LOG=run.log
VERILATOR       ?= verilator
TOP             ?= tb_db_engine
FILELIST        ?= verilog.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv hw/*.svh verification/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VERILATOR_FLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '*** FAILED ***' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_db_engine.sv
`timescale 1ns/1ns

`include "db_defs.svh"

module tb_db_engine import db_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int CLEAR_CYCLES = 64;
    localparam int NUM_KEYS     = 1 << `DB_KEY_WID;
    localparam int NUM_RANDOM   = 300;
    localparam int DRAIN_MAX    = 4;

    // Worst-case cycles per test, gaps and drain included
    localparam int T1_LEN      = NUM_KEYS + DRAIN_MAX + 1;
    localparam int T2_LEN      = 2 * NUM_RANDOM + DRAIN_MAX + 1;
    localparam int T3_LEN      = 4 * 10 + DRAIN_MAX + 1;
    localparam int T4_LEN      = 2 + NUM_KEYS + DRAIN_MAX + 1;
    localparam int T5_LEN      = 10 + DRAIN_MAX + 1;
    localparam int CYCLE_LIMIT = 2 * (RESET_CYCLES + 2 * CLEAR_CYCLES
                                      + T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN);

    logic                     clk;
    logic                     rst_n;
    logic                     init;
    logic                     init_done;
    logic                     cmd_valid;
    db_op_t                   cmd_op;
    logic [`DB_KEY_WID-1:0]   cmd_key;
    logic [`DB_VALUE_WID-1:0] cmd_value;
    logic                     cmd_rdy;
    logic                     rsp_valid;
    logic                     rsp_found;
    logic [`DB_VALUE_WID-1:0] rsp_value;

    tb_clkgen #(.PERIOD_NS(40), .RESET_CYCLES(RESET_CYCLES)) u_tb_clkgen (
        .clk   ( clk ),
        .rst_n ( rst_n )
    );

    db_engine u_db_engine (
        .clk       ( clk ),
        .rst_n     ( rst_n ),
        .init      ( init ),
        .init_done ( init_done ),
        .cmd_valid ( cmd_valid ),
        .cmd_op    ( cmd_op ),
        .cmd_key   ( cmd_key ),
        .cmd_value ( cmd_value ),
        .cmd_rdy   ( cmd_rdy ),
        .rsp_valid ( rsp_valid ),
        .rsp_found ( rsp_found ),
        .rsp_value ( rsp_value )
    );

    // --------------------------------------------------
    // Reference model and bookkeeping
    // --------------------------------------------------
    logic                     model_valid [0:NUM_KEYS-1];
    logic [`DB_VALUE_WID-1:0] model_value [0:NUM_KEYS-1];
    logic [`DB_VALUE_WID:0]   exp_q [$];
    int                       due_q [$];
    logic [15:0]              lfsr_q;
    int                       tick_cnt;
    int                       cycle_cnt;
    int                       err_cnt;
    int                       check_cnt;
    int                       err_base;
    int                       tests_run;
    int                       tests_pass;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [`DB_KEY_WID-1:0] rand_key();
        logic [`DB_KEY_WID-1:0] k;
        int                     i;
        for (i = 0; i < `DB_KEY_WID; i++) k = {k[`DB_KEY_WID-2:0], lfsr_step()};
        return k;
    endfunction

    function automatic logic [`DB_VALUE_WID-1:0] rand_value();
        logic [`DB_VALUE_WID-1:0] v;
        int                       i;
        for (i = 0; i < `DB_VALUE_WID; i++) v = {v[`DB_VALUE_WID-2:0], lfsr_step()};
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        assert (act === exp) else begin
            $display("ERR %0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic clear_model();
        int i;
        for (i = 0; i < NUM_KEYS; i++) begin
            model_valid[i] = 1'b0;
            model_value[i] = '0;
        end
    endtask

    task automatic check_rsp();
        logic [`DB_VALUE_WID:0] exp;
        int                     due;
        if (rsp_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("%0t: a response arrived with no GET outstanding", $time);
                err_cnt++;
            end
            if (exp_q.size() != 0) begin
                exp = exp_q.pop_front();
                due = due_q.pop_front();
                check_val("rsp_valid cycle", due, tick_cnt);
                check_val("rsp_found", exp[`DB_VALUE_WID], rsp_found);
                check_val("rsp_value", exp[`DB_VALUE_WID-1:0], rsp_value);
            end
        end
    endtask

    // Advance to the next falling edge and look at the response port
    task automatic tick();
        @(negedge clk);
        tick_cnt++;
        check_rsp();
    endtask

    // Command driven now is taken on the coming rising edge
    task automatic record_cmd(input db_op_t op, input logic [`DB_KEY_WID-1:0] key,
                              input logic [`DB_VALUE_WID-1:0] value);
        case (op)
            OP_SET: begin
                model_valid[key] = 1'b1;
                model_value[key] = value;
            end
            OP_DEL: begin
                model_valid[key] = 1'b0;
                model_value[key] = '0;
            end
            default: begin
                exp_q.push_back({model_valid[key], model_valid[key] ? model_value[key] : 16'h0});
                due_q.push_back(tick_cnt + 2);
            end
        endcase
    endtask

    task automatic send_cmd(input db_op_t op, input logic [`DB_KEY_WID-1:0] key,
                            input logic [`DB_VALUE_WID-1:0] value);
        tick();
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_key   = key;
        cmd_value = value;
        while (!cmd_rdy) tick();
        record_cmd(op, key, value);
    endtask

    task automatic idle_cycle();
        tick();
        cmd_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || n == 0) && n < DRAIN_MAX) begin
            idle_cycle();
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("%0t: %0d GET responses never arrived", $time, exp_q.size());
            err_cnt++;
        end
        exp_q.delete();
        due_q.delete();
    endtask

    task automatic wait_clear();
        int n;
        n = 0;
        while (!init_done && n < CLEAR_CYCLES + 16) begin
            tick();
            n++;
            if (!init_done) check_val("cmd_rdy", 0, cmd_rdy);
        end
        assert (init_done) else begin
            $display("%0t: init_done did not rise after clearing", $time);
            err_cnt++;
        end
        check_val("init_done cycles", CLEAR_CYCLES, n);
        check_val("cmd_rdy", 1, cmd_rdy);
    endtask

    task automatic get_all_keys();
        int i;
        for (i = 0; i < NUM_KEYS; i++) send_cmd(OP_GET, i[`DB_KEY_WID-1:0], '0);
        drain();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (err_cnt == err_base) begin
            tests_pass++;
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, err_cnt - err_base);
        end
        err_base = err_cnt;
    endtask

    // --------------------------------------------------
    // Watchdog
    // --------------------------------------------------
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("*** FAILED ***");
        $finish;
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        logic [`DB_KEY_WID-1:0] key;
        logic [`DB_KEY_WID-1:0] key_b;
        int                     i;

        lfsr_q     = 16'd94;
        init       = 1'b0;
        cmd_valid  = 1'b0;
        cmd_op     = OP_GET;
        cmd_key    = '0;
        cmd_value  = '0;
        tick_cnt   = 0;
        err_cnt    = 0;
        check_cnt  = 0;
        err_base   = 0;
        tests_run  = 0;
        tests_pass = 0;
        clear_model();
        wait (rst_n === 1'b1);

        // Clearing after reset, then every key empty
        wait_clear();
        get_all_keys();
        finish_test("reset_clear");

        for (i = 0; i < NUM_RANDOM; i++) begin
            if (lfsr_step()) idle_cycle();
            send_cmd(lfsr_step() ? OP_SET : OP_GET, rand_key(), rand_value());
        end
        drain();
        finish_test("random_set_get");

        for (i = 0; i < 4; i++) begin
            key = rand_key();
            send_cmd(OP_SET, key, rand_value());
            send_cmd(OP_GET, key, '0);
            idle_cycle();
            send_cmd(OP_DEL, key, '0);
            send_cmd(OP_GET, key, '0);
            if (lfsr_step()) idle_cycle();
            send_cmd(OP_SET, key, rand_value());
            send_cmd(OP_GET, key, '0);
        end
        drain();
        finish_test("del_then_get");

        // Init pulse with no command in the same cycle
        tick();
        init = 1'b1;
        clear_model();
        tick();
        init = 1'b0;
        check_val("cmd_rdy", 0, cmd_rdy);
        check_val("init_done", 0, init_done);
        wait_clear();
        get_all_keys();
        finish_test("init_mid_run");

        key   = rand_key();
        key_b = key + 1'b1;
        send_cmd(OP_SET, key, rand_value());
        send_cmd(OP_GET, key, '0);
        send_cmd(OP_GET, key, '0);
        send_cmd(OP_SET, key, rand_value());
        send_cmd(OP_GET, key, '0);
        send_cmd(OP_DEL, key, '0);
        send_cmd(OP_GET, key, '0);
        send_cmd(OP_SET, key_b, rand_value());
        send_cmd(OP_GET, key_b, '0);
        send_cmd(OP_GET, key, '0);
        drain();
        finish_test("back_to_back");

        $display("tests %0d passed %0d failed %0d checks %0d errors %0d",
                 tests_run, tests_pass, tests_run - tests_pass, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_db_engine

//--- verification/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release reset on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule : tb_clkgen

//--- hw/db_engine.sv
`timescale 1ns/1ns

`include "db_defs.svh"

module db_engine import db_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     init,
    output logic                     init_done,

    // Commands
    input  logic                     cmd_valid,
    input  db_op_t                   cmd_op,
    input  logic [`DB_KEY_WID-1:0]   cmd_key,
    input  logic [`DB_VALUE_WID-1:0] cmd_value,
    output logic                     cmd_rdy,

    // Responses
    output logic                     rsp_valid,
    output logic                     rsp_found,
    output logic [`DB_VALUE_WID-1:0] rsp_value
);

    // --------------------------------------------------
    // Store connections
    // --------------------------------------------------
    logic                     wr_req;
    logic [`DB_KEY_WID-1:0]   wr_key;
    logic                     wr_valid_bit;
    logic [`DB_VALUE_WID-1:0] wr_value;
    logic                     wr_rdy;
    logic                     rd_req;
    logic [`DB_KEY_WID-1:0]   rd_key;
    logic                     rd_ack;
    logic                     rd_valid_bit;
    logic [`DB_VALUE_WID-1:0] rd_value;

    db_cmd_ctrl i_db_cmd_ctrl (
        .clk          ( clk ),
        .rst_n        ( rst_n ),
        .cmd_valid    ( cmd_valid ),
        .cmd_op       ( cmd_op ),
        .cmd_key      ( cmd_key ),
        .cmd_value    ( cmd_value ),
        .cmd_rdy      ( cmd_rdy ),
        .wr_req       ( wr_req ),
        .wr_key       ( wr_key ),
        .wr_valid_bit ( wr_valid_bit ),
        .wr_value     ( wr_value ),
        .wr_rdy       ( wr_rdy ),
        .rd_req       ( rd_req ),
        .rd_key       ( rd_key ),
        .rd_ack       ( rd_ack ),
        .rd_valid_bit ( rd_valid_bit ),
        .rd_value     ( rd_value ),
        .rsp_valid    ( rsp_valid ),
        .rsp_found    ( rsp_found ),
        .rsp_value    ( rsp_value )
    );

    // Write ack and read ready are not needed by the controller
    db_store_array i_db_store_array (
        .clk          ( clk ),
        .rst_n        ( rst_n ),
        .init         ( init ),
        .init_done    ( init_done ),
        .wr_req       ( wr_req ),
        .wr_key       ( wr_key ),
        .wr_valid_bit ( wr_valid_bit ),
        .wr_value     ( wr_value ),
        .wr_rdy       ( wr_rdy ),
        .wr_ack       ( ),
        .rd_req       ( rd_req ),
        .rd_key       ( rd_key ),
        .rd_rdy       ( ),
        .rd_ack       ( rd_ack ),
        .rd_valid_bit ( rd_valid_bit ),
        .rd_value     ( rd_value )
    );

endmodule : db_engine

//--- hw/db_cmd_ctrl.sv
`timescale 1ns/1ns

`include "db_defs.svh"

module db_cmd_ctrl import db_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,

    // Command port
    input  logic                     cmd_valid,
    input  db_op_t                   cmd_op,
    input  logic [`DB_KEY_WID-1:0]   cmd_key,
    input  logic [`DB_VALUE_WID-1:0] cmd_value,
    output logic                     cmd_rdy,

    // Store write side
    output logic                     wr_req,
    output logic [`DB_KEY_WID-1:0]   wr_key,
    output logic                     wr_valid_bit,
    output logic [`DB_VALUE_WID-1:0] wr_value,
    input  logic                     wr_rdy,

    // Store read side
    output logic                     rd_req,
    output logic [`DB_KEY_WID-1:0]   rd_key,
    input  logic                     rd_ack,
    input  logic                     rd_valid_bit,
    input  logic [`DB_VALUE_WID-1:0] rd_value,

    // Response port
    output logic                     rsp_valid,
    output logic                     rsp_found,
    output logic [`DB_VALUE_WID-1:0] rsp_value
);

    // --------------------------------------------------
    // Command decode
    // --------------------------------------------------
    logic cmd_accept;
    logic get_accept;
    logic is_set;
    logic is_del;

    // Read and write ready move together, so one is enough
    assign cmd_rdy    = wr_rdy;
    assign cmd_accept = cmd_valid && cmd_rdy;

    assign is_set     = (cmd_op == OP_SET);
    assign is_del     = (cmd_op == OP_DEL);
    assign get_accept = cmd_accept && (cmd_op == OP_GET);

    // SET stores the value, DEL leaves a zeroed invalid entry
    assign wr_req       = cmd_accept && (is_set || is_del);
    assign wr_key       = cmd_key;
    assign wr_valid_bit = is_set;
    assign wr_value     = is_set ? cmd_value : '0;

    assign rd_req = get_accept;
    assign rd_key = cmd_key;

    // --------------------------------------------------
    // GET response
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_ack;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_ack) begin
            rsp_found <= rd_valid_bit;
            rsp_value <= rd_valid_bit ? rd_value : '0;
        end
    end

    // One read register in the store plus the response register
    a_rsp_has_get: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> $past(get_accept, 2));

endmodule : db_cmd_ctrl

//--- hw/db_store_array.sv
`timescale 1ns/1ns

`include "db_defs.svh"

module db_store_array import db_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     init,
    output logic                     init_done,

    // Write side
    input  logic                     wr_req,
    input  logic [`DB_KEY_WID-1:0]   wr_key,
    input  logic                     wr_valid_bit,
    input  logic [`DB_VALUE_WID-1:0] wr_value,
    output logic                     wr_rdy,
    output logic                     wr_ack,

    // Read side
    input  logic                     rd_req,
    input  logic [`DB_KEY_WID-1:0]   rd_key,
    output logic                     rd_rdy,
    output logic                     rd_ack,
    output logic                     rd_valid_bit,
    output logic [`DB_VALUE_WID-1:0] rd_value
);

    // --------------------------------------------------
    // Entry packing
    // --------------------------------------------------
    logic [`DB_ENTRY_WID-1:0] mem_wr_data;
    logic [`DB_ENTRY_WID-1:0] mem_rd_data;

    // Cleared words read back as invalid
    assign mem_wr_data = {wr_valid_bit, wr_value};
    assign {rd_valid_bit, rd_value} = mem_rd_data;

    // --------------------------------------------------
    // Record memory
    // --------------------------------------------------
    mem_ram_sdp_sync i_mem_ram_sdp_sync (
        .clk       ( clk ),
        .rst_n     ( rst_n ),
        .clear     ( init ),
        .init_done ( init_done ),
        .wr_req    ( wr_req ),
        .wr_addr   ( wr_key ),
        .wr_data   ( mem_wr_data ),
        .wr_rdy    ( wr_rdy ),
        .wr_ack    ( wr_ack ),
        .rd_req    ( rd_req ),
        .rd_addr   ( rd_key ),
        .rd_rdy    ( rd_rdy ),
        .rd_ack    ( rd_ack ),
        .rd_data   ( mem_rd_data )
    );

    // Every entry was wiped before the first read, so no X can escape
    a_rd_data_known: assert property (@(posedge clk) disable iff (!rst_n)
        rd_ack |-> !$isunknown({rd_valid_bit, rd_value}));

endmodule : db_store_array

//--- hw/mem_ram_sdp_sync.sv
`timescale 1ns/1ns

`include "db_defs.svh"

module mem_ram_sdp_sync import db_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     clear,
    output logic                     init_done,

    // Write port
    input  logic                     wr_req,
    input  logic [`DB_KEY_WID-1:0]   wr_addr,
    input  logic [`DB_ENTRY_WID-1:0] wr_data,
    output logic                     wr_rdy,
    output logic                     wr_ack,

    // Read port
    input  logic                     rd_req,
    input  logic [`DB_KEY_WID-1:0]   rd_addr,
    output logic                     rd_rdy,
    output logic                     rd_ack,
    output logic [`DB_ENTRY_WID-1:0] rd_data
);

    // --------------------------------------------------
    // Clearing FSM
    // --------------------------------------------------
    mem_init_state_t          state;
    mem_init_state_t          state_nxt;
    logic [`DB_KEY_WID-1:0]   clr_addr;
    logic                     clearing;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_RESET: state_nxt = ST_CLEAR;
            ST_CLEAR: if (clr_addr == '1) state_nxt = ST_READY;
            ST_READY: state_nxt = ST_READY;
            default:  state_nxt = ST_RESET;
        endcase
        // A clear request restarts the wipe from entry zero
        if (clear) state_nxt = ST_RESET;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_RESET;
        end else begin
            state <= state_nxt;
        end
    end

    // Both RESET and CLEAR write one entry per cycle
    assign clearing = (state == ST_RESET) || (state == ST_CLEAR);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clr_addr <= '0;
        end else if (clear) begin
            clr_addr <= '0;
        end else if (clearing) begin
            clr_addr <= clr_addr + 1'b1;
        end
    end

    assign init_done = (state == ST_READY);
    assign wr_rdy    = (state == ST_READY);
    assign rd_rdy    = (state == ST_READY);

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    logic [`DB_ENTRY_WID-1:0] mem [0:(1 << `DB_KEY_WID)-1];
    logic                     wr_take;
    logic                     rd_take;

    assign wr_take = wr_req && wr_rdy;
    assign rd_take = rd_req && rd_rdy;

    // Clearing owns the write port until ready
    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clr_addr] <= '0;
        end else if (wr_take) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_take) begin
            rd_data <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
        end else begin
            wr_ack <= wr_take;
            rd_ack <= rd_take;
        end
    end

    // --------------------------------------------------
    // Assertions
    // --------------------------------------------------
    // Requesters must wait for ready
    a_no_req_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_req || rd_req) |-> (wr_rdy && rd_rdy));

    // A read taken right after a write to the same address acks with the new word
    a_rd_after_wr: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_take && $past(wr_take) && (rd_addr == $past(wr_addr)))
        |=> (rd_ack && (rd_data == $past(wr_data, 2))));

endmodule : mem_ram_sdp_sync

//--- hw/db_pkg.sv
package db_pkg;

    // Command opcodes
    typedef enum logic [1:0] {
        OP_GET = 2'd0,
        OP_SET = 2'd1,
        OP_DEL = 2'd2
    } db_op_t;

    // Memory clearing FSM
    typedef enum logic [1:0] {
        ST_RESET = 2'd0,
        ST_CLEAR = 2'd1,
        ST_READY = 2'd2
    } mem_init_state_t;

endpackage : db_pkg

//--- hw/db_defs.svh
`ifndef DB_DEFS_SVH
`define DB_DEFS_SVH

// Key width, which also sets the RAM address width (64 entries)
`define DB_KEY_WID 6

// Stored value width
`define DB_VALUE_WID 16

// RAM word holds the valid bit above the value
`define DB_ENTRY_WID (`DB_VALUE_WID + 1)

`endif
